// File: files.f
source/scalar_pkg.sv
source/scalar_integer_divider.sv
source/scalar_execute.sv
source/scalar_result.sv
source/scalar_apb_decode.sv
source/scalar_top.sv
tests/scalar_checker.sv
tests/scalar_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the scalar unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f files.f --top-module scalar_tb -o scalar_sim \
  && ./obj_dir/scalar_sim > sim.log 2>&1 \
  || echo "Test FAILED" >> sim.log

cat sim.log
! grep -q "Test FAILED" sim.log

// File: source/scalar_apb_decode.sv
// APB slave register decode: operand registers, command issue and read data mux
module scalar_apb_decode
  import scalar_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,

  // APB slave port
  input  logic              PSEL,
  input  logic              PENABLE,
  input  logic              PWRITE,
  input  logic [ADDR_W-1:0] PADDR,
  input  logic [DATA_W-1:0] PWDATA,
  output logic [DATA_W-1:0] PRDATA,
  output logic              PREADY,
  output logic              PSLVERR,

  // Status and held result from the result block
  input  logic              busy,
  input  logic              status_done,
  input  logic              status_div_zero,
  input  scalar_res_t       held_res,

  // Command to execute
  output logic              cmd_valid,
  output scalar_cmd_t       cmd
);

  ////////////////////////////////////////////////////////////
  // Access phase decode
  ////////////////////////////////////////////////////////////

  logic              access;
  logic              wr_ctrl;
  logic              op_illegal;
  logic              refuse;
  logic              accept;
  logic [DATA_W-1:0] opa_q;
  logic [DATA_W-1:0] opb_q;

  // Zero wait states
  assign PREADY = 1'b1;

  assign access     = PSEL & PENABLE;
  assign wr_ctrl    = access & PWRITE & (PADDR == REG_CTRL);
  assign op_illegal = (PWDATA[1:0] == 2'd3);

  // Issued command not yet reflected in busy counts as busy too
  assign refuse  = wr_ctrl & (busy | cmd_valid | op_illegal);
  assign accept  = wr_ctrl & ~refuse;
  assign PSLVERR = refuse;

  ////////////////////////////////////////////////////////////
  // Operand registers and command issue
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      opa_q     <= '0;
      opb_q     <= '0;
      cmd_valid <= 1'b0;
      cmd       <= '0;
    end else begin
      // Operands stay writable while busy
      if (access && PWRITE && PADDR == REG_OPA) begin
        opa_q <= PWDATA;
      end
      if (access && PWRITE && PADDR == REG_OPB) begin
        opb_q <= PWDATA;
      end
      // Single-cycle pulse after the accepted CTRL access
      cmd_valid <= accept;
      if (accept) begin
        cmd.opcode    <= scalar_op_e'(PWDATA[1:0]);
        cmd.operand_a <= opa_q;
        cmd.operand_b <= opb_q;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read data mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (PADDR)
      REG_OPA:    PRDATA = opa_q;
      REG_OPB:    PRDATA = opb_q;
      REG_STATUS: PRDATA = {{(DATA_W-3){1'b0}}, status_div_zero, status_done, busy};
      REG_RES_LO: PRDATA = held_res.result_lo;
      REG_RES_HI: PRDATA = held_res.result_hi;
      // CTRL and unmapped offsets read zero
      default:    PRDATA = '0;
    endcase
  end

endmodule

// File: source/scalar_execute.sv
// Opcode dispatch FSM: ADD and SUB in one cycle, DIVU through the divider
module scalar_execute
  import scalar_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,

  // Command from decode
  input  logic        cmd_valid,
  input  scalar_cmd_t cmd,

  // Result to the result block
  output logic        res_valid,
  output scalar_res_t res
);

  exec_state_e       state_q;
  scalar_op_e        op_q;
  scalar_res_t       alu_q;
  scalar_res_t       alu_next;
  scalar_res_t       div_res;

  logic              div_start;
  logic              div_done;
  logic [DATA_W-1:0] quotient;
  logic [DATA_W-1:0] remainder;
  logic              div_zero;

  ////////////////////////////////////////////////////////////
  // ADD / SUB datapath
  ////////////////////////////////////////////////////////////

  always_comb begin
    logic [DATA_W:0] wide;
    // Carry or borrow lands in bit DATA_W
    if (cmd.opcode == OP_SUB) begin
      wide = {1'b0, cmd.operand_a} - {1'b0, cmd.operand_b};
    end else begin
      wide = {1'b0, cmd.operand_a} + {1'b0, cmd.operand_b};
    end
    alu_next.result_lo = wide[DATA_W-1:0];
    alu_next.result_hi = {{(DATA_W-1){1'b0}}, wide[DATA_W]};
    alu_next.div_zero  = 1'b0;
  end

  ////////////////////////////////////////////////////////////
  // Dispatch FSM
  ////////////////////////////////////////////////////////////

  // Divider loads in the cmd_valid cycle
  assign div_start = (state_q == EXEC_IDLE) & cmd_valid & (cmd.opcode == OP_DIVU);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= EXEC_IDLE;
      op_q    <= OP_ADD;
      alu_q   <= '0;
    end else begin
      case (state_q)
        EXEC_IDLE: begin
          if (cmd_valid) begin
            op_q  <= cmd.opcode;
            alu_q <= alu_next;
            case (cmd.opcode)
              OP_ADD, OP_SUB: state_q <= EXEC_FINISH;
              OP_DIVU:        state_q <= EXEC_DIVIDE;
              default:        state_q <= EXEC_IDLE;
            endcase
          end
        end
        EXEC_DIVIDE: begin
          // Wait for the last quotient bit
          if (div_done) begin
            state_q <= EXEC_FINISH;
          end
        end
        EXEC_FINISH: begin
          state_q <= EXEC_IDLE;
        end
        default: begin
          state_q <= EXEC_IDLE;
        end
      endcase
    end
  end

  // Quotient, remainder and flag packed from the held divider outputs
  assign div_res   = '{result_lo: quotient, result_hi: remainder, div_zero: div_zero};
  assign res_valid = (state_q == EXEC_FINISH);
  assign res       = (op_q == OP_DIVU) ? div_res : alu_q;

  scalar_integer_divider u_divider (
    .CLK       (CLK),
    .RST       (RST),
    .div_start (div_start),
    .div_done  (div_done),
    .dividend  (cmd.operand_a),
    .divisor   (cmd.operand_b),
    .quotient  (quotient),
    .remainder (remainder),
    .div_zero  (div_zero)
  );

endmodule

// File: source/scalar_integer_divider.sv
// Iterative restoring unsigned divider, one quotient bit per cycle
module scalar_integer_divider
  import scalar_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,

  // Control
  input  logic              div_start,
  output logic              div_done,

  // Data
  input  logic [DATA_W-1:0] dividend,
  input  logic [DATA_W-1:0] divisor,
  output logic [DATA_W-1:0] quotient,
  output logic [DATA_W-1:0] remainder,
  output logic              div_zero
);

  div_state_e           state_q;
  logic [DIV_CNT_W-1:0] count_q;
  logic [DATA_W-1:0]    divisor_q;
  logic [DATA_W-1:0]    rem_q;
  // Dividend bits shift out the top, quotient bits shift in the bottom
  logic [DATA_W-1:0]    quo_q;

  logic [DATA_W:0]      trial;
  logic [DATA_W:0]      diff;
  logic                 fits;

  ////////////////////////////////////////////////////////////
  // Shift-subtract step
  ////////////////////////////////////////////////////////////

  // Partial remainder with next dividend bit appended
  assign trial = {rem_q, quo_q[DATA_W-1]};
  assign diff  = trial - {1'b0, divisor_q};
  // No borrow means the divisor fits
  assign fits  = ~diff[DATA_W];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q   <= DIV_IDLE;
      count_q   <= '0;
      divisor_q <= '0;
      rem_q     <= '0;
      quo_q     <= '0;
      div_zero  <= 1'b0;
    end else begin
      case (state_q)
        DIV_IDLE: begin
          // Load cycle
          if (div_start) begin
            divisor_q <= divisor;
            quo_q     <= dividend;
            rem_q     <= '0;
            count_q   <= '0;
            // Zero divisor still runs all iterations
            div_zero  <= (divisor == '0);
            state_q   <= DIV_SHIFT;
          end
        end
        DIV_SHIFT: begin
          if (fits) begin
            rem_q <= diff[DATA_W-1:0];
          end else begin
            rem_q <= trial[DATA_W-1:0];
          end
          quo_q   <= {quo_q[DATA_W-2:0], fits};
          count_q <= count_q + 1'b1;
          if (count_q == DIV_CNT_W'(DATA_W-1)) begin
            state_q <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          // Results stay held in IDLE until the next load
          state_q <= DIV_IDLE;
        end
        default: begin
          state_q <= DIV_IDLE;
        end
      endcase
    end
  end

  assign div_done  = (state_q == DIV_DONE);
  assign quotient  = quo_q;
  assign remainder = rem_q;

endmodule

// File: source/scalar_pkg.sv
// Scalar integer unit package with widths, register map, enums and structs
package scalar_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Operand and result word width
  localparam int DATA_W = 32;
  // APB byte address width
  localparam int ADDR_W = 8;
  // Divider iteration counter width
  localparam int DIV_CNT_W = $clog2(DATA_W);

  ////////////////////////////////////////////////////////////
  // Register map (byte offsets)
  ////////////////////////////////////////////////////////////

  localparam logic [ADDR_W-1:0] REG_OPA    = 8'h00;
  localparam logic [ADDR_W-1:0] REG_OPB    = 8'h04;
  // Write only, opcode in bits 1:0
  localparam logic [ADDR_W-1:0] REG_CTRL   = 8'h08;
  // Read only, busy / done / div_zero
  localparam logic [ADDR_W-1:0] REG_STATUS = 8'h0C;
  localparam logic [ADDR_W-1:0] REG_RES_LO = 8'h10;
  localparam logic [ADDR_W-1:0] REG_RES_HI = 8'h14;

  ////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////

  // Code 3 is illegal and refused at the port
  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_SUB  = 2'd1,
    OP_DIVU = 2'd2
  } scalar_op_e;

  typedef enum logic [1:0] {
    EXEC_IDLE,
    EXEC_DIVIDE,
    EXEC_FINISH
  } exec_state_e;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_SHIFT,
    DIV_DONE
  } div_state_e;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////

  // Command captured at the CTRL write, 66 bits
  typedef struct packed {
    scalar_op_e          opcode;
    logic [DATA_W-1:0]   operand_a;
    logic [DATA_W-1:0]   operand_b;
  } scalar_cmd_t;

  // Result word pair plus divide-by-zero flag, 65 bits
  typedef struct packed {
    logic [DATA_W-1:0]   result_lo;
    logic [DATA_W-1:0]   result_hi;
    logic                div_zero;
  } scalar_res_t;

endpackage

// File: source/scalar_result.sv
// Result and status holding registers with busy, done and div_zero tracking
module scalar_result
  import scalar_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,

  input  logic        cmd_valid,
  input  logic        res_valid,
  input  scalar_res_t res,

  output logic        busy,
  output logic        status_done,
  output logic        status_div_zero,
  output scalar_res_t held_res
);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy            <= 1'b0;
      status_done     <= 1'b0;
      status_div_zero <= 1'b0;
      held_res        <= '0;
    end else begin
      // New command clears stale flags, last result stays readable
      if (cmd_valid) begin
        busy            <= 1'b1;
        status_done     <= 1'b0;
        status_div_zero <= 1'b0;
      end else if (res_valid) begin
        // Busy drops and done rises together
        busy            <= 1'b0;
        status_done     <= 1'b1;
        status_div_zero <= res.div_zero;
        held_res        <= res;
      end
    end
  end

endmodule

// File: source/scalar_top.sv
// Scalar integer unit top level, APB slave with decode, execute and result blocks
module scalar_top
  import scalar_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,

  // APB slave port
  input  logic              PSEL,
  input  logic              PENABLE,
  input  logic              PWRITE,
  input  logic [ADDR_W-1:0] PADDR,
  input  logic [DATA_W-1:0] PWDATA,
  output logic [DATA_W-1:0] PRDATA,
  output logic              PREADY,
  output logic              PSLVERR
);

  // Decode to execute
  logic        cmd_valid;
  scalar_cmd_t cmd;
  // Execute to result
  logic        res_valid;
  scalar_res_t res;
  // Result to decode
  logic        busy;
  logic        status_done;
  logic        status_div_zero;
  scalar_res_t held_res;

  scalar_apb_decode u_decode (
    .CLK             (CLK),
    .RST             (RST),
    .PSEL            (PSEL),
    .PENABLE         (PENABLE),
    .PWRITE          (PWRITE),
    .PADDR           (PADDR),
    .PWDATA          (PWDATA),
    .PRDATA          (PRDATA),
    .PREADY          (PREADY),
    .PSLVERR         (PSLVERR),
    .busy            (busy),
    .status_done     (status_done),
    .status_div_zero (status_div_zero),
    .held_res        (held_res),
    .cmd_valid       (cmd_valid),
    .cmd             (cmd)
  );

  scalar_execute u_execute (
    .CLK       (CLK),
    .RST       (RST),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .res_valid (res_valid),
    .res       (res)
  );

  scalar_result u_result (
    .CLK             (CLK),
    .RST             (RST),
    .cmd_valid       (cmd_valid),
    .res_valid       (res_valid),
    .res             (res),
    .busy            (busy),
    .status_done     (status_done),
    .status_div_zero (status_div_zero),
    .held_res        (held_res)
  );

endmodule

// File: tests/scalar_checker.sv
// Execute handshake checker, bound into scalar_execute
module scalar_checker
  import scalar_pkg::*;
(
  input logic        CLK,
  input logic        RST,
  input logic        cmd_valid,
  input scalar_cmd_t cmd,
  input logic        res_valid,
  input exec_state_e state_q
);
  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////////////////////////
  // Handshake pulses
  ////////////////////////////////////////////////////////////

  cmd_pulse: assert property (@(posedge CLK) disable iff (RST) cmd_valid |=> !cmd_valid)
    else $error("cmd_valid held for more than one cycle");

  // Decode must hold off while the divider runs
  no_cmd_in_divide: assert property (@(posedge CLK) disable iff (RST)
    (state_q == EXEC_DIVIDE) |-> !cmd_valid)
    else $error("cmd_valid arrived during a division");

  // Single cycle ALU latency
  alu_latency: assert property (@(posedge CLK) disable iff (RST)
    (cmd_valid && cmd.opcode != OP_DIVU) |=> res_valid)
    else $error("ADD or SUB result not one cycle after the command");

  // Load, DATA_W shift cycles, then finish
  div_latency: assert property (@(posedge CLK) disable iff (RST)
    (cmd_valid && cmd.opcode == OP_DIVU) |-> ##(DATA_W+2) res_valid)
    else $error("DIVU result not DATA_W+2 cycles after the command");

endmodule

bind scalar_execute scalar_checker u_checker (
  .CLK       (CLK),
  .RST       (RST),
  .cmd_valid (cmd_valid),
  .cmd       (cmd),
  .res_valid (res_valid),
  .state_q   (state_q)
);

// File: tests/scalar_tb.sv
// Testbench for the scalar integer unit, APB traffic checked against a reference model
module scalar_tb
  import scalar_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  logic              CLK = 1'b0;
  logic              RST;
  logic              PSEL;
  logic              PENABLE;
  logic              PWRITE;
  logic [ADDR_W-1:0] PADDR;
  logic [DATA_W-1:0] PWDATA;
  logic [DATA_W-1:0] PRDATA;
  logic              PREADY;
  logic              PSLVERR;

  // Pending checks, drained by the compare process
  string             tag_q[$];
  logic [DATA_W-1:0] got_q[$];
  logic [DATA_W-1:0] exp_q[$];
  logic [31:0]       rng_state = 32'hd21ea1ad;

  // 8 ns period
  always #4 CLK = ~CLK;

  scalar_top UUT (
    .CLK     (CLK),
    .RST     (RST),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PWRITE  (PWRITE),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .PRDATA  (PRDATA),
    .PREADY  (PREADY),
    .PSLVERR (PSLVERR)
  );

  ////////////////////////////////////////////////////////////
  // Reference model and random source
  ////////////////////////////////////////////////////////////

  function automatic scalar_res_t expected_result(input logic [1:0] op,
                                                  input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] b);
    scalar_res_t       r;
    r = '0;
    case (op)
      OP_ADD: begin
        // Carry whenever the 32-bit sum wraps below an operand
        r.result_lo = a + b;
        r.result_hi = {{(DATA_W-1){1'b0}}, (r.result_lo < a)};
      end
      OP_SUB: begin
        // Borrow whenever b exceeds a
        r.result_lo = a - b;
        r.result_hi = {{(DATA_W-1){1'b0}}, (a < b)};
      end
      OP_DIVU: begin
        if (b == '0) begin
          r.result_lo = '1;
          r.result_hi = a;
          r.div_zero  = 1'b1;
        end else begin
          r.result_lo = a / b;
          r.result_hi = a % b;
        end
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  ////////////////////////////////////////////////////////////
  // Failure handling and compare process
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic expect_word(input string tag, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    tag_q.push_back(tag);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  always @(posedge CLK) begin : compare
    string             tag;
    logic [DATA_W-1:0] got;
    logic [DATA_W-1:0] exp;
    while (got_q.size() > 0) begin
      tag = tag_q.pop_front();
      got = got_q.pop_front();
      exp = exp_q.pop_front();
      assert (got === exp) else begin
        $display("error at %0t ns: %s read %08h, expected %08h", $time, tag, got, exp);
        abort_run();
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // APB transfers, setup then access phase
  ////////////////////////////////////////////////////////////

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           output logic err);
    @(posedge CLK);
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b1;
    PADDR   <= addr;
    PWDATA  <= data;
    @(posedge CLK);
    PENABLE <= 1'b1;
    // PSLVERR settles mid access phase
    @(negedge CLK);
    err = PSLVERR;
    expect_word("PREADY on write", {{(DATA_W-1){1'b0}}, PREADY}, 32'd1);
    @(posedge CLK);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                          output logic err);
    @(posedge CLK);
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b0;
    PADDR   <= addr;
    @(posedge CLK);
    PENABLE <= 1'b1;
    @(negedge CLK);
    data = PRDATA;
    err  = PSLVERR;
    expect_word("PREADY on read", {{(DATA_W-1){1'b0}}, PREADY}, 32'd1);
    @(posedge CLK);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Operation helpers
  ////////////////////////////////////////////////////////////

  // Poll STATUS until busy clears, final STATUS returned
  task automatic wait_idle(output logic [DATA_W-1:0] st);
    logic err;
    int   polls;
    polls = 0;
    apb_read(REG_STATUS, st, err);
    while (st[0] == 1'b1) begin
      polls++;
      if (polls >= 100) begin
        $display("timeout: STATUS.busy still set after 100 polls");
        abort_run();
      end
      apb_read(REG_STATUS, st, err);
    end
  endtask

  task automatic check_held(input scalar_res_t exp);
    logic [DATA_W-1:0] lo;
    logic [DATA_W-1:0] hi;
    logic              err;
    apb_read(REG_RES_LO, lo, err);
    apb_read(REG_RES_HI, hi, err);
    expect_word("RESULT_LO", lo, exp.result_lo);
    expect_word("RESULT_HI", hi, exp.result_hi);
  endtask

  task automatic start_op(input logic [1:0] op, input logic [DATA_W-1:0] a,
                          input logic [DATA_W-1:0] b);
    logic err;
    apb_write(REG_OPA, a, err);
    apb_write(REG_OPB, b, err);
    apb_write(REG_CTRL, {{(DATA_W-2){1'b0}}, op}, err);
    expect_word("PSLVERR on accepted CTRL", {{(DATA_W-1){1'b0}}, err}, '0);
  endtask

  task automatic check_result(input logic [1:0] op, input logic [DATA_W-1:0] a,
                              input logic [DATA_W-1:0] b);
    logic [DATA_W-1:0] st;
    scalar_res_t       exp;
    wait_idle(st);
    exp = expected_result(op, a, b);
    // done set, busy clear, div_zero from the model
    expect_word("STATUS", st, {{(DATA_W-3){1'b0}}, exp.div_zero, 1'b1, 1'b0});
    check_held(exp);
  endtask

  task automatic run_op(input logic [1:0] op, input logic [DATA_W-1:0] a,
                        input logic [DATA_W-1:0] b);
    start_op(op, a, b);
    check_result(op, a, b);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] rd;
    logic              err;
    int                drain;
    RST     <= 1'b1;
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b0;
    PADDR   <= '0;
    PWDATA  <= '0;
    repeat (3) @(posedge CLK);
    RST <= 1'b0;

    // Reset state and operand readback
    apb_read(REG_STATUS, rd, err);
    expect_word("STATUS after reset", rd, '0);
    draw(a);
    draw(b);
    apb_write(REG_OPA, a, err);
    apb_write(REG_OPB, b, err);
    apb_read(REG_OPA, rd, err);
    expect_word("OPA readback", rd, a);
    apb_read(REG_OPB, rd, err);
    expect_word("OPB readback", rd, b);

    // ADD and SUB, random then carry and borrow corners
    repeat (50) begin
      draw(a);
      draw(b);
      run_op(OP_ADD, a, b);
      run_op(OP_SUB, a, b);
    end
    run_op(OP_ADD, 32'hffff_ffff, 32'd1);
    run_op(OP_SUB, 32'd0, 32'd1);

    // DIVU, small divisors every third pair for large quotients
    for (int i = 0; i < 50; i++) begin
      draw(a);
      draw(b);
      if (i % 3 == 0) begin
        b = b & 32'h0000_000f;
      end
      if (b == '0) begin
        b = 32'd7;
      end
      run_op(OP_DIVU, a, b);
    end

    // Divide by zero sets the sticky flag
    draw(a);
    run_op(OP_DIVU, a, 32'd0);

    // Next command clears done and div_zero, CTRL refused mid division
    a = 32'hfedc_ba98;
    b = 32'h0000_0123;
    start_op(OP_DIVU, a, b);
    apb_read(REG_STATUS, rd, err);
    expect_word("STATUS while dividing", rd, 32'h0000_0001);
    apb_write(REG_OPA, 32'h1234_5678, err);
    apb_write(REG_CTRL, {{(DATA_W-2){1'b0}}, OP_ADD}, err);
    expect_word("PSLVERR on CTRL while busy", {{(DATA_W-1){1'b0}}, err}, 32'd1);
    check_result(OP_DIVU, a, b);

    // Illegal opcode starts nothing
    apb_write(REG_CTRL, 32'd3, err);
    expect_word("PSLVERR on opcode 3", {{(DATA_W-1){1'b0}}, err}, 32'd1);
    apb_read(REG_STATUS, rd, err);
    expect_word("STATUS after opcode 3", rd, 32'h0000_0002);
    check_held(expected_result(OP_DIVU, a, b));

    drain = 0;
    while (got_q.size() > 0 && drain < 10) begin
      @(posedge CLK);
      drain++;
    end
    @(negedge CLK);
    if (got_q.size() == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("compare process left %0d checks unprocessed", got_q.size());
      abort_run();
    end
  end

endmodule
